// ==== design/video_timing_pkg.sv ====
// horizontal video timing
package video_timing_pkg;

    typedef logic [10:0] hres_t;            // horizontal pixel count

    localparam int H_TOTAL_DEF     = 800;   // total clocks per line
    localparam int H_OFFSCREEN_DEF = 160;   // clocks left of visible area

    // fetch window and scanout placement, relative to visible area
    localparam int MEM_LEAD  = 64;          // fetch opens this early before visible
    localparam int MEM_TAIL  = 8;           // fetch closes this early before line end
    localparam int SCAN_LEAD = 2;           // scanout begins this early (pipeline fill)

endpackage

// ==== design/playfield_pkg.sv ====
// playfield data and control types
package playfield_pkg;

    typedef logic [15:0] word_t;            // vram data word
    typedef logic [15:0] addr_t;            // vram word address
    typedef logic [7:0]  color_t;           // colour index

    // display depth code
    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                  // 1 bpp, fore/back attribute nibbles
        BPP_4      = 2'd1,                  // 4 bpp, colour extension nibble
        BPP_8      = 2'd2                   // 8 bpp
    } bpp_t;

    localparam int ATTR_FORE = 8;           // foreground nibble in attribute word
    localparam int ATTR_BACK = 12;          // background / extension nibble

    // plane control registers
    typedef struct packed {
        logic       blank;                  // park plane on border colour
        addr_t      start_addr;             // frame start word address
        word_t      line_len;               // words added per display line
        color_t     colorbase;              // XORed into every index
        bpp_t       bpp;                    // depth mode
        logic [1:0] h_repeat;               // extra clocks per pixel
        logic [1:0] v_repeat;               // extra scanlines per line
    } pf_ctrl_t;

    // fetched display words, fetch fsm to shifter
    typedef struct packed {
        word_t attr;                        // attribute word
        word_t data0;                       // first word, pixels 0..
        word_t data1;
        word_t data2;
        word_t data3;
        logic  ready;                       // one group complete
    } pf_words_t;

endpackage

// ==== design/playfield_window.sv ====
// fetch window and scanout timing
module playfield_window import video_timing_pkg::*; #(
    parameter int H_TOTAL     = H_TOTAL_DEF,
    parameter int H_OFFSCREEN = H_OFFSCREEN_DEF
) (
    input  logic  clk,
    input  logic  reset_i,
    input  hres_t h_count_i,                // current horizontal count
    input  logic  v_visible_i,              // visible line
    input  logic  h_line_last_pixel_i,      // last clock of line
    input  logic  blank_i,                  // plane blanked
    input  hres_t vid_left_i,               // first scanout column
    input  hres_t vid_right_i,              // scanout end column
    output logic  fetch_active_o,           // fetch window open
    output logic  line_fetch_start_o,       // strobe, window about to open
    output logic  scanout_start_o,          // strobe, shifting begins next clock
    output logic  scanout_o                 // pixels shifting
);

    localparam hres_t MEM_BEGIN  = hres_t'(H_OFFSCREEN - MEM_LEAD);
    localparam hres_t MEM_END    = hres_t'(H_TOTAL - MEM_TAIL);
    localparam hres_t SCAN_BEGIN = hres_t'(H_OFFSCREEN - SCAN_LEAD);

    logic  fetch_next;                      // fetch flag before blank gating
    hres_t start_hcount;                    // h count that starts scanout
    hres_t end_hcount;                      // h count that stops scanout

    always_comb begin
        if (fetch_active_o) begin
            fetch_next = (h_count_i != MEM_END);                    // close near line end
        end else begin
            fetch_next = v_visible_i && (h_count_i == MEM_BEGIN);   // open on visible lines
        end
    end

    // strobe is not blank gated so the shifter still parks on border
    assign line_fetch_start_o = !fetch_active_o && fetch_next;
    assign scanout_start_o    = fetch_active_o && (h_count_i == start_hcount);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_active_o <= 1'b0;
            start_hcount   <= '0;
            end_hcount     <= '0;
            scanout_o      <= 1'b0;
        end else begin
            fetch_active_o <= fetch_next && !blank_i;
            if (line_fetch_start_o) begin
                start_hcount <= SCAN_BEGIN + vid_left_i;    // latch limits for this line
                end_hcount   <= SCAN_BEGIN + vid_right_i;
            end
            if (scanout_start_o) begin
                scanout_o <= 1'b1;
            end
            if (h_count_i == end_hcount || h_line_last_pixel_i) begin
                scanout_o <= 1'b0;                          // right edge or forced at line end
            end
        end
    end

    // the start strobe always gets shifting running on the next clock
    a_scan_in_window: assert property (@(posedge clk) disable iff (reset_i)
        scanout_start_o |=> scanout_o);

endmodule

// ==== design/playfield_fetch_fsm.sv ====
// display word fetch state machine
module playfield_fetch_fsm import playfield_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      fetch_active_i,       // fetch window open
    input  bpp_t      bpp_i,                // depth, sets words per group
    input  logic      buf_full_i,           // shifter holding buffer occupied
    input  addr_t     cur_addr_i,           // running display address
    input  word_t     vram_data_i,          // vram read data
    output logic      next_addr_o,          // address consumed, advance
    output logic      vram_sel_o,           // vram read select
    output addr_t     vram_addr_o,          // vram word address
    output pf_words_t words_o               // captured words and ready strobe
);

    typedef enum logic [2:0] {
        IDLE,                               // waiting for fetch window
        ADDR,                               // issue first word address
        WAIT,                               // second address, data in flight
        READ_0,                             // capture word 0 (and attribute)
        READ_1,
        READ_2,
        READ_3
    } fetch_st_t;

    fetch_st_t state, state_next;
    logic      sel_next;                    // select for next clock
    logic      initial_buf, initial_next;   // first group of the line
    logic      ready_next;

    assign next_addr_o = sel_next;          // every select uses one address

    always_comb begin
        state_next   = state;
        sel_next     = 1'b0;
        ready_next   = 1'b0;
        initial_next = initial_buf;
        case (state)
            IDLE: begin
                initial_next = 1'b1;                        // next group is the first
                if (fetch_active_i) begin
                    state_next = ADDR;
                end
            end
            ADDR: begin
                if (!fetch_active_i) begin
                    state_next = IDLE;                      // window closed
                end else if (!buf_full_i) begin
                    sel_next   = 1'b1;                      // word 0
                    state_next = WAIT;
                end
            end
            WAIT: begin
                sel_next     = (bpp_i != BPP_1_ATTR);       // word 1
                ready_next   = !initial_buf;                // previous group now complete
                initial_next = 1'b0;
                state_next   = READ_0;
            end
            READ_0: begin
                if (bpp_i == BPP_1_ATTR) begin
                    state_next = ADDR;                      // single word group
                end else begin
                    sel_next   = (bpp_i != BPP_4);          // word 2 in 8 bpp
                    state_next = READ_1;
                end
            end
            READ_1: begin
                if (bpp_i == BPP_4) begin
                    state_next = ADDR;
                end else begin
                    sel_next   = 1'b1;                      // word 3
                    state_next = READ_2;
                end
            end
            READ_2: state_next = READ_3;
            READ_3: state_next = ADDR;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= IDLE;
            initial_buf   <= 1'b0;
            vram_sel_o    <= 1'b0;
            words_o.ready <= 1'b0;
        end else begin
            state         <= state_next;
            initial_buf   <= initial_next;
            vram_sel_o    <= sel_next;
            words_o.ready <= ready_next;
        end
    end

    // address and captured words
    always_ff @(posedge clk) begin
        if (sel_next) begin
            vram_addr_o <= cur_addr_i;
        end
        case (state)
            READ_0: begin
                words_o.data0 <= vram_data_i;
                words_o.attr  <= vram_data_i;               // attribute in 1 bpp
            end
            READ_1: begin
                words_o.data1        <= vram_data_i;
                words_o.attr[15:11]  <= 5'b0;               // no extension from data word
            end
            READ_2: words_o.data2 <= vram_data_i;
            READ_3: words_o.data3 <= vram_data_i;
            default: ;
        endcase
    end

    a_no_sel_idle: assert property (@(posedge clk) disable iff (reset_i)
        state == IDLE |-> !vram_sel_o);

endmodule

// ==== design/playfield_line_addr.sv ====
// line start and display address
module playfield_line_addr import playfield_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  pf_ctrl_t ctrl_i,                // plane registers
    input  logic     last_frame_pixel_i,    // end of frame
    input  logic     h_line_last_pixel_i,   // end of line
    input  logic     line_fetch_start_i,    // fetch window opening
    input  logic     line_start_set_i,      // register write to line start
    input  addr_t    line_start_addr_i,
    input  logic     next_addr_i,           // fetch consumed an address
    output addr_t    cur_addr_o             // running display address
);

    addr_t      line_start;                 // start of current display line
    logic [1:0] v_count;                    // scanlines left on this line
    logic       start_written;              // line start set by write, skip next step

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start    <= '0;
            cur_addr_o    <= '0;
            v_count       <= '0;
            start_written <= 1'b0;
        end else begin
            if (next_addr_i) begin
                cur_addr_o <= cur_addr_o + 1'b1;
            end
            if (line_start_set_i) begin
                line_start    <= line_start_addr_i;
                start_written <= 1'b1;
            end
            if (line_fetch_start_i) begin
                cur_addr_o <= line_start;
            end
            if (h_line_last_pixel_i) begin
                cur_addr_o    <= line_start;                // rewind for repeat
                start_written <= 1'b0;
                if (v_count == 2'd0) begin
                    v_count <= ctrl_i.v_repeat;
                    if (!start_written) begin
                        line_start <= line_start + ctrl_i.line_len;
                    end
                end else begin
                    v_count <= v_count - 1'b1;
                end
            end
            if (ctrl_i.blank || last_frame_pixel_i) begin
                cur_addr_o    <= ctrl_i.start_addr;         // rewind to frame start
                line_start    <= ctrl_i.start_addr;
                v_count       <= ctrl_i.v_repeat;
                start_written <= 1'b0;
            end
        end
    end

    a_vcount_range: assert property (@(posedge clk) disable iff (reset_i || ctrl_i.blank)
        h_line_last_pixel_i |=> v_count <= ctrl_i.v_repeat);

endmodule

// ==== design/playfield_pixel_shift.sv ====
// pixel expansion and output shifter
module playfield_pixel_shift import playfield_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  pf_words_t  words_i,             // fetched group
    input  bpp_t       bpp_i,
    input  logic [1:0] h_repeat_i,          // extra clocks per pixel
    input  color_t     colorbase_i,
    input  color_t     border_color_i,
    input  logic       line_fetch_start_i,
    input  logic       scanout_start_i,
    input  logic       scanout_i,
    output logic       buf_full_o,          // holding buffer occupied
    output color_t     color_o
);

    logic [63:0] pix_buf;                   // 8 expanded pixels waiting
    logic [63:0] pix_shift;                 // 8 pixels shifting out, msb first
    logic [1:0]  h_count;                   // repeat countdown
    logic [2:0]  pix_x;                     // pixel within group
    logic        scanout_q;                 // delayed scanout, for end detect

    // group to 8 colour indices, pixel 0 in the top byte
    function automatic logic [63:0] expand(input pf_words_t w, input bpp_t bpp);
        logic [63:0] px;
        logic [31:0] d4;
        logic [63:0] d8;
        logic [3:0]  fore;
        logic [3:0]  back;
        fore = w.attr[ATTR_FORE +: 4];
        back = w.attr[ATTR_BACK +: 4];
        d4   = {w.data0, w.data1};
        d8   = {w.data0, w.data1, w.data2, w.data3};
        for (int k = 0; k < 8; k++) begin
            case (bpp)
                BPP_1_ATTR: px[63 - 8*k -: 8] = {4'h0, w.data0[7 - k] ? fore : back};
                BPP_4:      px[63 - 8*k -: 8] = {back, d4[31 - 4*k -: 4]};
                default:    px[63 - 8*k -: 8] = d8[63 - 8*k -: 8] ^ {back, 4'h0};
            endcase
        end
        return px;
    endfunction

    assign color_o = pix_shift[63:56] ^ colorbase_i;

    always_ff @(posedge clk) begin
        if (words_i.ready) begin
            pix_buf <= expand(words_i, bpp_i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_shift  <= '0;
            buf_full_o <= 1'b0;
            h_count    <= '0;
            pix_x      <= '0;
            scanout_q  <= 1'b0;
        end else begin
            scanout_q <= scanout_i;
            if (words_i.ready) begin
                buf_full_o <= 1'b1;
            end
            if (scanout_i) begin
                if (h_count != 2'd0) begin
                    h_count <= h_count - 1'b1;              // hold pixel
                end else begin
                    h_count <= h_repeat_i;
                    pix_x   <= pix_x + 1'b1;
                    if (pix_x == 3'd7) begin
                        pix_shift  <= pix_buf;              // next group
                        buf_full_o <= 1'b0;                 // lets fsm fetch again
                    end else begin
                        pix_shift <= {pix_shift[55:0], border_color_i};
                    end
                end
            end
            if (line_fetch_start_i) begin
                buf_full_o        <= 1'b0;
                pix_shift[63:56]  <= border_color_i;        // border until scanout
            end
            if (scanout_start_i) begin
                pix_shift  <= pix_buf;
                buf_full_o <= 1'b0;
                h_count    <= h_repeat_i;
                pix_x      <= '0;
            end
            if (scanout_q && !scanout_i) begin
                pix_shift[63:56] <= border_color_i;         // right edge reached
            end
        end
    end

endmodule

// ==== design/video_playfield.sv ====
// bitmap playfield generator
module video_playfield import video_timing_pkg::*, playfield_pkg::*; #(
    parameter int H_TOTAL     = H_TOTAL_DEF,
    parameter int H_OFFSCREEN = H_OFFSCREEN_DEF
) (
    input  logic     clk,
    input  logic     reset_i,
    input  hres_t    h_count_i,
    input  logic     v_visible_i,
    input  logic     h_line_last_pixel_i,
    input  logic     last_frame_pixel_i,
    input  color_t   border_color_i,
    input  hres_t    vid_left_i,
    input  hres_t    vid_right_i,
    input  pf_ctrl_t pf_ctrl_i,             // plane registers
    input  logic     line_start_set_i,      // line start register write
    input  addr_t    line_start_addr_i,
    output logic     vram_sel_o,
    output addr_t    vram_addr_o,
    input  word_t    vram_data_i,
    output color_t   color_o,               // index XOR colorbase
    output logic     scanout_o
);

    logic      fetch_active;
    logic      line_fetch_start;
    logic      scanout_start;
    logic      buf_full;
    logic      next_addr;
    addr_t     cur_addr;
    pf_words_t words;

    playfield_window #(
        .H_TOTAL     (H_TOTAL),
        .H_OFFSCREEN (H_OFFSCREEN)
    ) u_window (
        .clk                 (clk),
        .reset_i             (reset_i),
        .h_count_i           (h_count_i),
        .v_visible_i         (v_visible_i),
        .h_line_last_pixel_i (h_line_last_pixel_i),
        .blank_i             (pf_ctrl_i.blank),
        .vid_left_i          (vid_left_i),
        .vid_right_i         (vid_right_i),
        .fetch_active_o      (fetch_active),
        .line_fetch_start_o  (line_fetch_start),
        .scanout_start_o     (scanout_start),
        .scanout_o           (scanout_o)
    );

    playfield_fetch_fsm u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_active_i (fetch_active),
        .bpp_i          (pf_ctrl_i.bpp),
        .buf_full_i     (buf_full),
        .cur_addr_i     (cur_addr),
        .vram_data_i    (vram_data_i),
        .next_addr_o    (next_addr),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .words_o        (words)
    );

    playfield_line_addr u_line_addr (
        .clk                 (clk),
        .reset_i             (reset_i),
        .ctrl_i              (pf_ctrl_i),
        .last_frame_pixel_i  (last_frame_pixel_i),
        .h_line_last_pixel_i (h_line_last_pixel_i),
        .line_fetch_start_i  (line_fetch_start),
        .line_start_set_i    (line_start_set_i),
        .line_start_addr_i   (line_start_addr_i),
        .next_addr_i         (next_addr),
        .cur_addr_o          (cur_addr)
    );

    playfield_pixel_shift u_shift (
        .clk                (clk),
        .reset_i            (reset_i),
        .words_i            (words),
        .bpp_i              (pf_ctrl_i.bpp),
        .h_repeat_i         (pf_ctrl_i.h_repeat),
        .colorbase_i        (pf_ctrl_i.colorbase),
        .border_color_i     (border_color_i),
        .line_fetch_start_i (line_fetch_start),
        .scanout_start_i    (scanout_start),
        .scanout_i          (scanout_o),
        .buf_full_o         (buf_full),
        .color_o            (color_o)
    );

endmodule

// ==== bench/tb_video_playfield.sv ====
// playfield generator testbench
module tb_video_playfield import video_timing_pkg::*, playfield_pkg::*; ();

    localparam int H_TOTAL     = 200;               // short lines keep the run small
    localparam int H_OFFSCREEN = 80;
    localparam int LINES       = 6;                 // lines per frame, 1..4 visible
    localparam int VID_LEFT    = 0;
    localparam int VID_RIGHT   = 120;
    localparam int NUM_ROWS    = 9;
    localparam int SET_AT_H    = 100;               // column of the line start write
    localparam addr_t SET_ADDR = 16'h01c3;          // address written to the line start
    localparam color_t BORDER  = 8'h3c;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 * LINES * H_TOTAL + 500;

    // one row of the stimulus table
    typedef struct packed {
        bpp_t       bpp;
        logic [1:0] h_repeat;
        logic [1:0] v_repeat;
        addr_t      start_addr;
        word_t      line_len;
        color_t     colorbase;
        logic       blank;
        logic       set_start;                      // pulse line start write on line 2
    } test_row_t;

    logic      clk;
    logic      reset;
    hres_t     h_count;
    logic      v_visible;
    logic      h_last;                              // last clock of every line
    logic      frame_last;                          // frame wrap strobe
    color_t    border_color;
    hres_t     vid_left;
    hres_t     vid_right;
    pf_ctrl_t  pf_ctrl;
    logic      line_start_set;
    addr_t     line_start_addr;
    logic      vram_sel;
    addr_t     vram_addr;
    word_t     vram_data = '0;
    color_t    color;
    logic      scanout;

    word_t     vram [256];                          // vram contents, low 8 address bits
    logic      sel_d = 1'b0;                        // select seen one clock ago
    addr_t     addr_d = '0;
    test_row_t rows [NUM_ROWS];
    integer    seed;
    int        errors;
    int        pass_tests;
    int        fail_tests;
    int        cycle_count;

    video_playfield #(
        .H_TOTAL     (H_TOTAL),
        .H_OFFSCREEN (H_OFFSCREEN)
    ) UUT (
        .clk                 (clk),
        .reset_i             (reset),
        .h_count_i           (h_count),
        .v_visible_i         (v_visible),
        .h_line_last_pixel_i (h_last),
        .last_frame_pixel_i  (frame_last),
        .border_color_i      (border_color),
        .vid_left_i          (vid_left),
        .vid_right_i         (vid_right),
        .pf_ctrl_i           (pf_ctrl),
        .line_start_set_i    (line_start_set),
        .line_start_addr_i   (line_start_addr),
        .vram_sel_o          (vram_sel),
        .vram_addr_o         (vram_addr),
        .vram_data_i         (vram_data),
        .color_o             (color),
        .scanout_o           (scanout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // synchronous vram, data for a select is present at the second rising edge
    always @(negedge clk) begin
        if (sel_d) begin
            vram_data <= vram[addr_d[7:0]];
        end
        sel_d  <= vram_sel;
        addr_d <= vram_addr;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run stopped after %0d clock cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    function automatic test_row_t make_row(input bpp_t bpp, input int hr, input int vr,
                                           input addr_t sa, input word_t ll,
                                           input color_t cb, input bit bl, input bit ss);
        test_row_t r;
        r.bpp        = bpp;
        r.h_repeat   = 2'(hr);
        r.v_repeat   = 2'(vr);
        r.start_addr = sa;
        r.line_len   = ll;
        r.colorbase  = cb;
        r.blank      = bl;
        r.set_start  = ss;
        return r;
    endfunction

    function automatic pf_ctrl_t to_ctrl(input test_row_t r);
        pf_ctrl_t c;
        c.blank      = r.blank;
        c.start_addr = r.start_addr;
        c.line_len   = r.line_len;
        c.colorbase  = r.colorbase;
        c.bpp        = r.bpp;
        c.h_repeat   = r.h_repeat;
        c.v_repeat   = r.v_repeat;
        return c;
    endfunction

    // start address of visible line n, counted from 0
    function automatic addr_t line_start_exp(input test_row_t r, input int n);
        int    rep;
        int    step;
        addr_t base;
        rep = r.v_repeat + 1;
        if (r.set_start && n >= 2) begin
            base = SET_ADDR;                        // written during visible line 1
            step = n / rep - 2 / rep;               // stepping continues from the write
        end else begin
            base = r.start_addr;
            step = n / rep;
        end
        return addr_t'(base + step * r.line_len);
    endfunction

    // colour of pixel p of a line whose words start at first
    function automatic color_t pixel_exp(input test_row_t r, input addr_t first, input int p);
        int          words;
        int          g;
        int          k;
        addr_t       a;
        word_t       w [4];
        word_t       attr;
        logic [3:0]  fore;
        logic [3:0]  back;
        logic [63:0] d;
        color_t      px;
        words = (r.bpp == BPP_1_ATTR) ? 1 : ((r.bpp == BPP_4) ? 2 : 4);
        g = p / 8;
        k = p % 8;
        for (int i = 0; i < 4; i++) begin
            a    = first + addr_t'(g * words + i);
            w[i] = vram[a[7:0]];
        end
        // attribute upper bits are cleared once a second word arrives
        attr = (words > 1) ? (w[0] & 16'h07ff) : w[0];
        fore = attr[ATTR_FORE +: 4];
        back = attr[ATTR_BACK +: 4];
        d    = {w[0], w[1], w[2], w[3]};
        case (r.bpp)
            BPP_1_ATTR: px = {4'h0, w[0][7 - k] ? fore : back};
            BPP_4:      px = {back, d[63 - 4*k -: 4]};
            default:    px = d[63 - 8*k -: 8] ^ {back, 4'h0};
        endcase
        return px ^ r.colorbase;
    endfunction

    task automatic log_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
            pass_tests++;
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
            fail_tests++;
        end
    endtask

    task automatic check_reset_state();
        assert (!vram_sel && !scanout && color == 8'h00) else
            log_error($sformatf("reset state wrong, sel %0b scanout %0b colour %h",
                                vram_sel, scanout, color));
    endtask

    // one scanline, outputs sampled at the falling edge before new inputs go out
    task automatic run_line(input test_row_t r, input int line, input bit check);
        bit     visible;
        int     samples;                            // scanout clocks seen
        int     sels;                               // vram reads seen
        addr_t  start;
        addr_t  next_addr;
        color_t exp_color;
        visible   = (line >= 1 && line <= 4);
        start     = line_start_exp(r, line - 1);
        next_addr = start;
        samples   = 0;
        sels      = 0;
        for (int h = 0; h < H_TOTAL; h++) begin
            @(negedge clk);
            if (check && h > 0) begin              // h 0 still shows the previous line
                if (r.blank) begin
                    assert (!vram_sel) else log_error("vram read in a blanked row");
                    assert (color == (BORDER ^ r.colorbase)) else
                        log_error($sformatf("blank colour %h, expected %h",
                                            color, BORDER ^ r.colorbase));
                end else if (visible) begin
                    if (vram_sel) begin
                        assert (vram_addr == next_addr) else
                            log_error($sformatf("line %0d address %h, expected %h",
                                                line, vram_addr, next_addr));
                        next_addr = vram_addr + 1'b1;
                        sels++;
                    end
                    if (scanout) begin
                        exp_color = pixel_exp(r, start, samples / (r.h_repeat + 1));
                        assert (color == exp_color) else
                            log_error($sformatf("line %0d clock %0d colour %h, expected %h",
                                                line, samples, color, exp_color));
                        samples++;
                    end
                end else begin
                    assert (!vram_sel && !scanout) else
                        log_error($sformatf("activity on hidden line %0d", line));
                end
            end
            h_count         = hres_t'(h);
            v_visible       = visible;
            h_last          = (h == H_TOTAL - 1);
            frame_last      = (line == 0 && h == H_TOTAL - 1);   // frame wraps before line 1
            pf_ctrl         = to_ctrl(r);
            line_start_set  = r.set_start && line == 2 && h == SET_AT_H;
            line_start_addr = SET_ADDR;
        end
        if (check && visible && !r.blank) begin
            assert (sels > 0) else log_error($sformatf("no vram reads on line %0d", line));
            assert (samples == VID_RIGHT - VID_LEFT) else
                log_error($sformatf("scanout lasted %0d clocks on line %0d, expected %0d",
                                    samples, line, VID_RIGHT - VID_LEFT));
        end
    endtask

    initial begin
        int errs_before;
        errors          = 0;
        pass_tests      = 0;
        fail_tests      = 0;
        reset           = 1'b1;
        h_count         = '0;
        v_visible       = 1'b0;
        h_last          = 1'b0;
        frame_last      = 1'b0;
        border_color    = BORDER;
        vid_left        = hres_t'(VID_LEFT);
        vid_right       = hres_t'(VID_RIGHT);
        pf_ctrl         = '0;
        line_start_set  = 1'b0;
        line_start_addr = '0;
        seed            = 32'h7759;
        for (int i = 0; i < 256; i++) begin
            vram[i] = word_t'($random(seed));
        end
        // bpp, h rep, v rep, start, line len, colorbase, blank, line start write
        rows[0] = make_row(BPP_1_ATTR, 0, 0, 16'h0000, 16'h0010, 8'h00, 0, 0);
        rows[1] = make_row(BPP_1_ATTR, 2, 1, 16'h0020, 16'h0008, 8'h5a, 0, 0);
        rows[2] = make_row(BPP_4,      0, 0, 16'h0040, 16'h0020, 8'h00, 0, 0);
        rows[3] = make_row(BPP_4,      3, 2, 16'hfff0, 16'h0011, 8'h81, 0, 0);  // wraps
        rows[4] = make_row(BPP_8,      0, 0, 16'h0100, 16'h0040, 8'h3c, 0, 0);
        rows[5] = make_row(BPP_8,      1, 3, 16'h0007, 16'h0025, 8'hf0, 0, 0);
        rows[6] = make_row(BPP_4,      1, 1, 16'h0010, 16'h0030, 8'h0f, 1, 0);
        rows[7] = make_row(BPP_8,      0, 0, 16'h0080, 16'h0018, 8'h00, 0, 1);
        rows[8] = make_row(BPP_1_ATTR, 1, 2, 16'h0030, 16'h0009, 8'ha5, 0, 1);

        errs_before = errors;
        for (int c = 0; c < 8; c++) begin          // 8 clocks of reset
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();                        // first clock out of reset
        close_test("reset state", errs_before);

        for (int t = 0; t < NUM_ROWS; t++) begin
            errs_before = errors;
            for (int frame = 0; frame < 2; frame++) begin
                for (int line = 0; line < LINES; line++) begin
                    run_line(rows[t], line, frame == 1);    // first frame settles
                end
            end
            close_test($sformatf("row %0d bpp %0d h_rep %0d v_rep %0d blank %0b write %0b",
                                 t, rows[t].bpp, rows[t].h_repeat, rows[t].v_repeat,
                                 rows[t].blank, rows[t].set_start), errs_before);
        end

        $display("tests passed %0d, tests with errors %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/video_timing_pkg.sv
design/playfield_pkg.sv
design/playfield_window.sv
design/playfield_fetch_fsm.sv
design/playfield_line_addr.sv
design/playfield_pixel_shift.sv
design/video_playfield.sv
bench/tb_video_playfield.sv
